// File: Makefile
TOP := tb_dbg_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f sim.f
	out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: design/dbg_cmd_engine.sv
`timescale 1ns/1ns
`default_nettype none

module dbg_cmd_engine (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  logic                                    i_rx_valid,
    output logic                                    o_rx_ready,
    input  dbg_uart_pkg::rx_frame_t                 i_rx_frame,
    output logic                                    o_tx_valid,
    input  logic                                    i_tx_ready,
    output dbg_uart_pkg::byte_t                     o_tx_byte,
    input  logic [dbg_cpu_pkg::REGFILE_BYTES*8-1:0] i_regfile,
    input  dbg_cpu_pkg::word_t                      i_if_id,
    output logic                                    o_imem_we,
    output logic [dbg_cpu_pkg::IMEM_ADDR_W-1:0]     o_imem_addr,
    output dbg_cpu_pkg::word_t                      o_imem_data,
    output logic                                    o_cpu_enable
);
    import dbg_cpu_pkg::*;

    localparam int REG_IDX_W = $clog2(REGFILE_BYTES);
    localparam int IF_IDX_W  = $clog2(IF_ID_BYTES);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_CNT,
        S_LOAD_DATA,
        S_STEP,
        S_REPLY
    } state_t;

    state_t      state;
    logic        mode_cont;             // 1 continuous, 0 single step
    logic        dump_sel;              // 0 register file, 1 IF/ID
    logic [7:0]  idx;
    logic [7:0]  dump_len;              // Zero for a bare acknowledge
    logic [7:0]  words_left;
    logic [1:0]  byte_cnt;
    logic [23:0] word_buf;
    logic [7:0]  rx_byte;
    logic        rx_good;
    logic        loading;
    logic [7:0]  dump_byte;

    assign rx_byte    = i_rx_frame.data;
    assign o_rx_ready = (state == S_IDLE) || loading;
    assign rx_good    = i_rx_valid && o_rx_ready && !i_rx_frame.frame_err;
    assign loading    = (state == S_LOAD_CNT) || (state == S_LOAD_DATA);

    assign dump_byte = dump_sel ? i_if_id[{idx[IF_IDX_W-1:0], 3'b000} +: 8]
                                : i_regfile[{idx[REG_IDX_W-1:0], 3'b000} +: 8];
    assign o_tx_valid   = (state == S_REPLY);
    assign o_tx_byte    = (idx == dump_len) ? ACK_BYTE : dump_byte;   // Ack closes every reply
    assign o_cpu_enable = (mode_cont && !loading) || (state == S_STEP);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state       <= S_IDLE;
            mode_cont   <= 1'b0;
            dump_sel    <= 1'b0;
            idx         <= '0;
            dump_len    <= '0;
            words_left  <= '0;
            byte_cnt    <= '0;
            o_imem_we   <= 1'b0;
            o_imem_addr <= '0;
        end else begin
            o_imem_we <= 1'b0;
            if (o_imem_we) begin
                o_imem_addr <= o_imem_addr + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    idx      <= '0;
                    dump_len <= '0;
                    if (rx_good) begin
                        case (rx_byte)
                            CMD_DUMP_REGS: begin
                                dump_sel <= 1'b0;
                                dump_len <= 8'(REGFILE_BYTES);
                                state    <= S_REPLY;
                            end
                            CMD_DUMP_IF_ID: begin
                                dump_sel <= 1'b1;
                                dump_len <= 8'(IF_ID_BYTES);
                                state    <= S_REPLY;
                            end
                            CMD_LOAD_PROG: begin
                                state <= S_LOAD_CNT;
                            end
                            CMD_MODE_CONT: begin
                                mode_cont <= 1'b1;
                                state     <= S_REPLY;
                            end
                            CMD_MODE_STEP: begin
                                mode_cont <= 1'b0;
                                state     <= S_REPLY;
                            end
                            CMD_STEP: begin
                                state <= mode_cont ? S_REPLY : S_STEP;
                            end
                            default: begin
                                state <= S_IDLE;    // Unknown code gets no reply
                            end
                        endcase
                    end
                end
                S_LOAD_CNT: begin
                    if (rx_good) begin
                        o_imem_addr <= '0;
                        byte_cnt    <= '0;
                        words_left  <= rx_byte;
                        state       <= (rx_byte == 8'd0) ? S_REPLY : S_LOAD_DATA;
                    end
                end
                S_LOAD_DATA: begin
                    if (rx_good) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            o_imem_we  <= 1'b1;
                            words_left <= words_left - 1'b1;
                            if (words_left == 8'd1) begin
                                state <= S_REPLY;
                            end
                        end
                    end
                end
                S_STEP: begin
                    state <= S_REPLY;       // Enable held for this one cycle
                end
                default: begin
                    if (i_tx_ready) begin
                        if (idx == dump_len) begin
                            state <= S_IDLE;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Little-endian word assembly
    always_ff @(posedge i_clk) begin
        if (state == S_LOAD_DATA && rx_good) begin
            word_buf <= {rx_byte, word_buf[23:8]};
            if (byte_cnt == 2'd3) begin
                o_imem_data <= {rx_byte, word_buf};
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dbg_cpu_pkg.sv
`default_nettype none

package dbg_cpu_pkg;

    typedef logic [31:0] word_t;

    localparam int NUM_REGS      = 32;
    localparam int REGFILE_BYTES = NUM_REGS * $bits(word_t) / 8;   // Register dump length
    localparam int IF_ID_BYTES   = $bits(word_t) / 8;              // IF/ID latch is one word
    localparam int IMEM_ADDR_W   = 6;

    // Command codes
    localparam logic [7:0] CMD_DUMP_REGS  = 8'h01;
    localparam logic [7:0] CMD_DUMP_IF_ID = 8'h02;
    localparam logic [7:0] CMD_LOAD_PROG  = 8'h07;
    localparam logic [7:0] CMD_MODE_CONT  = 8'h08;
    localparam logic [7:0] CMD_MODE_STEP  = 8'h09;
    localparam logic [7:0] CMD_STEP       = 8'h0A;

    localparam logic [7:0] ACK_BYTE       = 8'h52;   // ASCII 'R'

endpackage

`default_nettype wire

// File: design/dbg_top.sv
`timescale 1ns/1ns
`default_nettype none

module dbg_top (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  logic                                    i_uart_rx,
    output logic                                    o_uart_tx,
    input  logic [dbg_cpu_pkg::REGFILE_BYTES*8-1:0] i_regfile,
    input  dbg_cpu_pkg::word_t                      i_if_id,
    output logic                                    o_imem_we,
    output logic [dbg_cpu_pkg::IMEM_ADDR_W-1:0]     o_imem_addr,
    output dbg_cpu_pkg::word_t                      o_imem_data,
    output logic                                    o_cpu_enable
);
    import dbg_uart_pkg::*;

    logic      rx_valid;
    rx_frame_t rx_frame;
    logic      cmd_valid;
    logic      cmd_ready;
    rx_frame_t cmd_frame;
    logic      rsp_valid;
    logic      rsp_ready;
    byte_t     rsp_byte;
    logic      tx_valid;
    logic      tx_ready;
    byte_t     tx_byte;

    uart_rx u_uart_rx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_rx    (i_uart_rx),
        .o_valid (rx_valid),
        .o_frame (rx_frame)
    );

    stream_fifo #(.T(rx_frame_t), .DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (rx_valid),
        .o_ready (),                    // Frame dropped when full
        .i_data  (rx_frame),
        .o_valid (cmd_valid),
        .i_ready (cmd_ready),
        .o_data  (cmd_frame)
    );

    dbg_cmd_engine u_engine (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_valid   (cmd_valid),
        .o_rx_ready   (cmd_ready),
        .i_rx_frame   (cmd_frame),
        .o_tx_valid   (rsp_valid),
        .i_tx_ready   (rsp_ready),
        .o_tx_byte    (rsp_byte),
        .i_regfile    (i_regfile),
        .i_if_id      (i_if_id),
        .o_imem_we    (o_imem_we),
        .o_imem_addr  (o_imem_addr),
        .o_imem_data  (o_imem_data),
        .o_cpu_enable (o_cpu_enable)
    );

    stream_fifo #(.T(byte_t), .DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (rsp_valid),
        .o_ready (rsp_ready),
        .i_data  (rsp_byte),
        .o_valid (tx_valid),
        .i_ready (tx_ready),
        .o_data  (tx_byte)
    );

    uart_tx u_uart_tx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (tx_valid),
        .o_ready (tx_ready),
        .i_byte  (tx_byte),
        .o_tx    (o_uart_tx)
    );

endmodule

`default_nettype wire

// File: design/dbg_uart_pkg.sv
`default_nettype none

package dbg_uart_pkg;

    localparam int CLKS_PER_BIT = 8;    // One 10-bit frame lasts 80 cycles
    localparam int DATA_BITS    = 8;
    localparam int FIFO_DEPTH   = 4;

    typedef logic [DATA_BITS-1:0] byte_t;

    // Received frame as handed to the command engine
    typedef struct packed {
        byte_t data;
        logic  frame_err;               // Stop bit sampled low
    } rx_frame_t;

endpackage

`default_nettype wire

// File: design/stream_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign o_ready = (count != FULL_CNT);
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];       // Head visible right after the write edge
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_rx,
    output logic                    o_valid,
    output dbg_uart_pkg::rx_frame_t o_frame
);
    import dbg_uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(DATA_BITS);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_BITS - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic [CNT_W-1:0] clk_cnt;
    logic [BIT_W-1:0] bit_cnt;
    byte_t            shift;
    logic             bit_mid;

    assign bit_mid = (clk_cnt == FULL_CNT);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;         // Held-low line does not retrigger
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == HALF_CNT) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;   // Reject glitches
                    end
                end
                RX_DATA: begin
                    if (bit_mid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_mid) begin
                        o_valid <= 1'b1;        // Middle of the stop bit
                        state   <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_mid) begin
            shift <= {rx_sync, shift[DATA_BITS-1:1]};   // LSB first
        end
        if (state == RX_STOP && bit_mid) begin
            o_frame.data      <= shift;
            o_frame.frame_err <= !rx_sync;
        end
    end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_valid,
    output logic                o_ready,
    input  dbg_uart_pkg::byte_t i_byte,
    output logic                o_tx
);
    import dbg_uart_pkg::*;

    localparam int FRAME_BITS = DATA_BITS + 2;
    localparam int CNT_W      = $clog2(CLKS_PER_BIT);
    localparam int BIT_W      = $clog2(FRAME_BITS);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(FRAME_BITS - 1);

    logic                  busy;
    logic [CNT_W-1:0]      clk_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] shreg;
    logic                  accept;
    logic                  bit_end;

    assign o_ready = !busy;
    assign accept  = i_valid && !busy;
    assign bit_end = busy && (clk_cnt == FULL_CNT);
    assign o_tx    = busy ? shreg[0] : 1'b1;    // Line idles high

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            clk_cnt <= clk_cnt + 1'b1;
            if (bit_end) begin
                clk_cnt <= '0;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_BIT) begin
                    busy <= 1'b0;   // Stop bit done
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            shreg <= {1'b1, i_byte, 1'b0};  // Stop, data, start
        end else if (bit_end) begin
            shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: dv/dbg_top_sva.sv
`timescale 1ns/1ns
`default_nettype none

module dbg_top_sva (
    input logic                                i_clk,
    input logic                                i_reset,
    input logic                                i_imem_we,
    input logic [dbg_cpu_pkg::IMEM_ADDR_W-1:0] i_imem_addr,
    input logic                                i_uart_tx
);
    import dbg_cpu_pkg::*;

    logic [IMEM_ADDR_W:0] words_done;   // Writes seen in the current load

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            words_done <= '0;
        end else if (i_imem_we) begin
            words_done <= (i_imem_addr == '0) ? (IMEM_ADDR_W + 1)'(1)
                                              : words_done + (IMEM_ADDR_W + 1)'(1);
        end
    end

    we_single_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_imem_we |=> !i_imem_we)
        else $error("o_imem_we stayed high for two cycles in a row");

    addr_within_load: assert property (@(posedge i_clk) disable iff (i_reset)
        i_imem_we |-> ({1'b0, i_imem_addr} <= words_done))
        else $error("o_imem_addr ran ahead of the words written in this load");

    tx_idle_in_reset: assert property (@(posedge i_clk)
        i_reset |-> i_uart_tx)
        else $error("o_uart_tx was low during reset");

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic o_clk,
    output logic o_reset
);
    localparam int HALF_PERIOD  = 4;    // 8 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;                 // Released away from the active edge
    end

endmodule

`default_nettype wire

// File: dv/tb_dbg_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dbg_top;
    import dbg_uart_pkg::*;
    import dbg_cpu_pkg::*;

    localparam int MAX_LOAD     = 8;
    localparam int MODE_LOAD    = 2;    // Words loaded while in continuous mode
    localparam int FRAME_CYCLES = (DATA_BITS + 2) * CLKS_PER_BIT;
    localparam int QUIET_FRAMES = 6;    // Three silent windows of two frames
    localparam int FRAMES_SENT  = 3 + (2 + 4 * MAX_LOAD) + (1 + 2 + 4 * MODE_LOAD + 1) + 3;
    localparam int FRAMES_RECV  = 1 + (REGFILE_BYTES + 1) + (IF_ID_BYTES + 1) + 1 + 3
                                  + (IF_ID_BYTES + 1);
    localparam int TIMEOUT_CYCLES = (FRAMES_SENT + FRAMES_RECV + QUIET_FRAMES)
                                    * FRAME_CYCLES * 2;

    logic                       clk;
    logic                       rst;
    logic                       uart_rx;
    logic                       uart_tx;
    logic [REGFILE_BYTES*8-1:0] regfile;
    word_t                      if_id;
    logic                       imem_we;
    logic [IMEM_ADDR_W-1:0]     imem_addr;
    word_t                      imem_data;
    logic                       cpu_enable;

    integer                 seed = 32'h4bd4_cfcb;
    int                     cycle_cnt = 0;
    int                     en_cycles = 0;
    int                     tx_start_cycle = 0;   // Start bit of the latest byte on o_uart_tx
    int                     last_we_cycle = 0;
    byte_t                  rx_q[$];    // Bytes decoded from o_uart_tx
    byte_t                  exp_q[$];
    logic [IMEM_ADDR_W-1:0] wr_addr_q[$];
    word_t                  wr_data_q[$];

    tb_clkgen clkgen0 (
        .o_clk   (clk),
        .o_reset (rst)
    );

    dbg_top dut0 (
        .i_clk        (clk),
        .i_reset      (rst),
        .i_uart_rx    (uart_rx),
        .o_uart_tx    (uart_tx),
        .i_regfile    (regfile),
        .i_if_id      (if_id),
        .o_imem_we    (imem_we),
        .o_imem_addr  (imem_addr),
        .o_imem_data  (imem_data),
        .o_cpu_enable (cpu_enable)
    );

    bind dbg_top dbg_top_sva sva0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_imem_we   (o_imem_we),
        .i_imem_addr (o_imem_addr),
        .i_uart_tx   (o_uart_tx)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic send_frame(input byte_t data, input logic stop_bit);
        logic [DATA_BITS+1:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int b = 0; b < DATA_BITS + 2; b++) begin
            uart_rx = bits[b];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        uart_rx = 1'b1;
    endtask

    task automatic send_cmd(input byte_t data);
        send_frame(data, 1'b1);
    endtask

    task automatic expect_reply;
        byte_t got;
        while (exp_q.size() > 0) begin
            while (rx_q.size() == 0) @(negedge clk);
            got = rx_q.pop_front();
            check_value("o_uart_tx byte", 32'(got), 32'(exp_q.pop_front()));
        end
    endtask

    task automatic expect_silence;
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        check_value("o_uart_tx byte count", 32'(rx_q.size()), 32'd0);
    endtask

    task automatic load_program(input int n);
        word_t words[$];
        word_t w;
        send_cmd(CMD_LOAD_PROG);
        send_cmd(8'(n));
        repeat (8) @(negedge clk);
        check_value("o_cpu_enable", 32'(cpu_enable), 32'd0);   // Held off while loading
        for (int i = 0; i < n; i++) begin
            w = $random(seed);
            words.push_back(w);
            for (int k = 0; k < 4; k++) begin
                send_cmd(w[8*k +: 8]);                          // Little-endian
            end
        end
        exp_q.push_back(ACK_BYTE);
        expect_reply;
        if (tx_start_cycle <= last_we_cycle) begin
            fail_run("The load acknowledge began before the last program write");
        end
        check_value("o_imem_we pulses", 32'(wr_addr_q.size()), 32'(n));
        for (int i = 0; i < n; i++) begin
            check_value("o_imem_addr", 32'(wr_addr_q.pop_front()), 32'(i));
            check_value("o_imem_data", wr_data_q.pop_front(), words[i]);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: the DUT did not finish its replies in time");
        end
    end

    always @(negedge clk) begin
        if (cpu_enable === 1'b1) begin
            en_cycles++;
        end
        if (imem_we === 1'b1) begin
            last_we_cycle = cycle_cnt;
            wr_addr_q.push_back(imem_addr);
            wr_data_q.push_back(imem_data);
        end
    end

    initial begin : serial_monitor
        byte_t data;
        forever begin
            @(negedge clk);
            if (!rst && uart_tx === 1'b0) begin
                tx_start_cycle = cycle_cnt;
                repeat (CLKS_PER_BIT / 2) @(negedge clk);   // Middle of the start bit
                for (int b = 0; b < DATA_BITS; b++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    data[b] = uart_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (uart_tx !== 1'b1) begin
                    fail_run("Stop bit on o_uart_tx was low");
                end
                rx_q.push_back(data);
            end
        end
    end

    initial begin : stimulus
        int n;
        int en_before;
        uart_rx = 1'b1;
        regfile = '0;
        if_id   = '0;
        @(negedge clk);
        while (rst) @(negedge clk);
        repeat (2) @(negedge clk);

        check_value("o_cpu_enable", 32'(cpu_enable), 32'd0);
        check_value("o_imem_we", 32'(imem_we), 32'd0);
        check_value("o_uart_tx", 32'(uart_tx), 32'd1);
        en_before = en_cycles;
        send_cmd(CMD_STEP);
        exp_q.push_back(ACK_BYTE);
        expect_reply;
        check_value("o_cpu_enable cycles", 32'(en_cycles - en_before), 32'd1);

        for (int r = 0; r < NUM_REGS; r++) begin
            regfile[32*r +: 32] = $random(seed);
        end
        send_cmd(CMD_DUMP_REGS);
        for (int i = 0; i < REGFILE_BYTES; i++) begin
            exp_q.push_back(regfile[8*i +: 8]);
        end
        exp_q.push_back(ACK_BYTE);
        expect_reply;

        if_id = $random(seed);
        send_cmd(CMD_DUMP_IF_ID);
        for (int i = 0; i < IF_ID_BYTES; i++) begin
            exp_q.push_back(if_id[8*i +: 8]);
        end
        exp_q.push_back(ACK_BYTE);
        expect_reply;

        n = ($random(seed) & 7) + 1;
        load_program(n);

        send_cmd(CMD_MODE_CONT);
        exp_q.push_back(ACK_BYTE);
        expect_reply;
        check_value("o_cpu_enable", 32'(cpu_enable), 32'd1);
        load_program(MODE_LOAD);
        repeat (2) @(negedge clk);
        check_value("o_cpu_enable", 32'(cpu_enable), 32'd1);
        send_cmd(CMD_MODE_STEP);
        exp_q.push_back(ACK_BYTE);
        expect_reply;
        check_value("o_cpu_enable", 32'(cpu_enable), 32'd0);

        send_cmd(8'h55);                // Not a command code
        expect_silence;
        send_frame(CMD_DUMP_REGS, 1'b0);
        expect_silence;
        if_id = $random(seed);
        send_cmd(CMD_DUMP_IF_ID);
        for (int i = 0; i < IF_ID_BYTES; i++) begin
            exp_q.push_back(if_id[8*i +: 8]);
        end
        exp_q.push_back(ACK_BYTE);
        expect_reply;
        expect_silence;

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
design/dbg_uart_pkg.sv
design/dbg_cpu_pkg.sv
design/uart_rx.sv
design/stream_fifo.sv
design/dbg_cmd_engine.sv
design/uart_tx.sv
design/dbg_top.sv
dv/tb_clkgen.sv
dv/dbg_top_sva.sv
dv/tb_dbg_top.sv
